//--- verilog/xfer_pkg.sv
package xfer_pkg;

  // host BRAM port
  localparam int HOST_ADDR_W = 15;
  localparam int HOST_DATA_W = 32;

  // downstream AXI link
  localparam int AXI_ADDR_W = 64;
  localparam int AXI_SIZE_W = 3;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_RESP_W = 2;

  localparam int REQ_W = AXI_SIZE_W + AXI_ADDR_W; // {size, addr}

  // request queues and flow control
  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W    = 3; // 0..QUEUE_DEPTH
  localparam int DROP_W      = 16;
  localparam int NUM_CHAN    = 2;

  typedef enum logic [0:0] {
    CH_WRITE = 1'b0, // AW
    CH_READ  = 1'b1  // AR
  } chan_e;

  typedef enum logic [HOST_ADDR_W-1:0] {
    REG_STAGE0       = 15'h000, // addr low word
    REG_STAGE1       = 15'h004, // addr high word
    REG_STAGE2       = 15'h008, // size in [2:0]
    REG_PUSH_AW      = 15'h020,
    REG_PUSH_AR      = 15'h040,
    REG_CREDITS      = 15'h050, // ar [11:8], aw [3:0]
    REG_BRESP        = 15'h054, // valid [31], id [7:4], resp [1:0]
    REG_DROPS        = 15'h058,
    REG_LINK_RST_SET = 15'h0c0,
    REG_LINK_RST_CLR = 15'h0c4
  } host_reg_e;

endpackage

//--- verilog/host_regs.sv
`timescale 1ns/1ps

module host_regs (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic [xfer_pkg::HOST_ADDR_W-1:0]   host_addr,
  input  logic [xfer_pkg::HOST_DATA_W-1:0]   host_din,
  input  logic                               host_en,
  input  logic [3:0]                         host_we,
  output logic [xfer_pkg::HOST_DATA_W-1:0]   host_dout,
  output logic [xfer_pkg::NUM_CHAN-1:0]      push,
  output logic [xfer_pkg::REQ_W-1:0]         push_data,
  input  logic [xfer_pkg::NUM_CHAN-1:0]      credit_return,
  input  logic                               b_valid_status,
  input  logic [xfer_pkg::AXI_ID_W-1:0]      b_id,
  input  logic [xfer_pkg::AXI_RESP_W-1:0]    b_resp,
  output logic                               b_ack,
  output logic                               ocu_rstn
);

  import xfer_pkg::*;

  host_reg_e               op;
  logic                    wr_en;
  logic                    rd_en;
  logic [HOST_DATA_W-1:0]  stage_lo;
  logic [HOST_DATA_W-1:0]  stage_hi;
  logic [AXI_SIZE_W-1:0]   stage_size;
  logic [CREDIT_W-1:0]     credits [NUM_CHAN];
  logic [NUM_CHAN-1:0]     push_req;
  logic [NUM_CHAN-1:0]     credit_ok;
  logic [DROP_W-1:0]       drops;
  logic                    ocu_rstn_sw;
  logic [HOST_DATA_W-1:0]  rd_word;

  assign op    = host_reg_e'(host_addr);
  assign wr_en = host_en && (host_we != '0);
  assign rd_en = host_en && (host_we == '0);

  assign push_req[CH_WRITE] = wr_en && (op == REG_PUSH_AW);
  assign push_req[CH_READ]  = wr_en && (op == REG_PUSH_AR);

  // a push still in flight has not been taken off the count yet
  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      credit_ok[c] = credits[c] > CREDIT_W'(push[c]);
    end
  end

  // a status read frees the B slot
  assign b_ack = rd_en && (op == REG_BRESP);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (op)
        REG_STAGE0: stage_lo <= host_din;
        REG_STAGE1: stage_hi <= host_din;
        REG_STAGE2: stage_size <= host_din[AXI_SIZE_W-1:0];
        default: ;
      endcase
    end
    if (|(push_req & credit_ok)) begin
      push_data <= {stage_size, stage_hi, stage_lo};
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      push        <= '0;
      drops       <= '0;
      ocu_rstn_sw <= 1'b1; // link released
      ocu_rstn    <= 1'b0;
      for (int c = 0; c < NUM_CHAN; c++) begin
        credits[c] <= CREDIT_W'(QUEUE_DEPTH);
      end
    end else begin
      push     <= push_req & credit_ok;
      ocu_rstn <= ocu_rstn_sw;
      // push and return in the same cycle cancel out
      for (int c = 0; c < NUM_CHAN; c++) begin
        credits[c] <= credits[c] - CREDIT_W'(push[c]) + CREDIT_W'(credit_return[c]);
      end
      if (|(push_req & ~credit_ok)) begin
        drops <= drops + 1'b1; // request lost for lack of credit
      end
      if (wr_en && op == REG_LINK_RST_SET) begin
        ocu_rstn_sw <= 1'b0;
      end else if (wr_en && op == REG_LINK_RST_CLR) begin
        ocu_rstn_sw <= 1'b1;
      end
    end
  end

  always_comb begin
    rd_word = '0; // unmapped reads return zero
    case (op)
      REG_STAGE0: rd_word = stage_lo;
      REG_STAGE1: rd_word = stage_hi;
      REG_STAGE2: rd_word[AXI_SIZE_W-1:0] = stage_size;
      REG_CREDITS: begin
        rd_word[11:8] = 4'(credits[CH_READ]);
        rd_word[3:0]  = 4'(credits[CH_WRITE]);
      end
      REG_BRESP: begin
        rd_word[31]                = b_valid_status;
        rd_word[4 +: AXI_ID_W]     = b_id;
        rd_word[0 +: AXI_RESP_W]   = b_resp;
      end
      REG_DROPS: rd_word[DROP_W-1:0] = drops;
      default: ;
    endcase
  end

  // read data lands one cycle after the access and holds until the next read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      host_dout <= rd_word;
    end
  end

endmodule

//--- verilog/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue #(
  parameter int DEPTH = xfer_pkg::QUEUE_DEPTH
) (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        push,
  input  logic [xfer_pkg::REQ_W-1:0]  push_data,
  input  logic                        q_pop,
  output logic                        q_valid,
  output logic [xfer_pkg::REQ_W-1:0]  q_data,
  output logic                        credit_return
);

  import xfer_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [REQ_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             wr_ok;
  logic             rd_ok;

  assign full    = count == (PTR_W+1)'(DEPTH);
  assign wr_ok   = push && !full;
  assign rd_ok   = q_pop && q_valid;
  assign q_valid = count != '0;
  assign q_data  = mem[rd_ptr]; // head shows without a read request

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1; // wraps, DEPTH is a power of two
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      count         <= count + (PTR_W+1)'(wr_ok) - (PTR_W+1)'(rd_ok);
      credit_return <= rd_ok; // slot freed, hand one credit back
    end
  end

endmodule

//--- verilog/axi_req_issue.sv
`timescale 1ns/1ps

module axi_req_issue (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [xfer_pkg::NUM_CHAN-1:0]     q_valid,
  input  logic [xfer_pkg::REQ_W-1:0]        q_data_aw,
  input  logic [xfer_pkg::REQ_W-1:0]        q_data_ar,
  output logic [xfer_pkg::NUM_CHAN-1:0]     q_pop,
  output logic [xfer_pkg::AXI_ADDR_W-1:0]   awaddr,
  output logic [xfer_pkg::AXI_SIZE_W-1:0]   awsize,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [xfer_pkg::AXI_ADDR_W-1:0]   araddr,
  output logic [xfer_pkg::AXI_SIZE_W-1:0]   arsize,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic [xfer_pkg::AXI_ID_W-1:0]     bid,
  input  logic [xfer_pkg::AXI_RESP_W-1:0]   bresp,
  input  logic                              bvalid,
  output logic                              bready,
  input  logic                              b_ack,
  output logic                              b_valid_status,
  output logic [xfer_pkg::AXI_ID_W-1:0]     b_id,
  output logic [xfer_pkg::AXI_RESP_W-1:0]   b_resp
);

  import xfer_pkg::*;

  logic [REQ_W-1:0]    head [NUM_CHAN];
  logic [REQ_W-1:0]    out_data [NUM_CHAN];
  logic [NUM_CHAN-1:0] out_valid;
  logic [NUM_CHAN-1:0] chan_ready;

  assign head[CH_WRITE]       = q_data_aw;
  assign head[CH_READ]        = q_data_ar;
  assign chan_ready[CH_WRITE] = awready;
  assign chan_ready[CH_READ]  = arready;

  // refill when empty or when the current request leaves this cycle
  assign q_pop = q_valid & (~out_valid | chan_ready);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      out_valid <= '0;
    end else begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (q_pop[c]) begin
          out_valid[c] <= 1'b1;
        end else if (chan_ready[c]) begin
          out_valid[c] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (q_pop[c]) out_data[c] <= head[c];
    end
  end

  assign awvalid          = out_valid[CH_WRITE];
  assign {awsize, awaddr} = out_data[CH_WRITE];
  assign arvalid          = out_valid[CH_READ];
  assign {arsize, araddr} = out_data[CH_READ];

  // single B slot, held until the host reads it
  assign bready = !b_valid_status;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      b_valid_status <= 1'b0;
    end else if (bvalid && bready) begin
      b_valid_status <= 1'b1;
    end else if (b_ack) begin
      b_valid_status <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (bvalid && bready) begin
      b_id   <= bid;
      b_resp <= bresp;
    end
  end

endmodule

//--- verilog/kernel_bridge.sv
`timescale 1ns/1ps

module kernel_bridge (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [xfer_pkg::HOST_ADDR_W-1:0]  host_addr,
  input  logic [xfer_pkg::HOST_DATA_W-1:0]  host_din,
  output logic [xfer_pkg::HOST_DATA_W-1:0]  host_dout,
  input  logic                              host_en,
  input  logic [3:0]                        host_we,
  output logic                              ocu_rstn,
  output logic [xfer_pkg::AXI_ADDR_W-1:0]   awaddr,
  output logic [xfer_pkg::AXI_SIZE_W-1:0]   awsize,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [xfer_pkg::AXI_ADDR_W-1:0]   araddr,
  output logic [xfer_pkg::AXI_SIZE_W-1:0]   arsize,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic [xfer_pkg::AXI_ID_W-1:0]     bid,
  input  logic [xfer_pkg::AXI_RESP_W-1:0]   bresp,
  input  logic                              bvalid,
  output logic                              bready
);

  import xfer_pkg::*;

  logic [NUM_CHAN-1:0]   push;
  logic [REQ_W-1:0]      push_data;
  logic [NUM_CHAN-1:0]   credit_return;
  logic [NUM_CHAN-1:0]   q_valid;
  logic [NUM_CHAN-1:0]   q_pop;
  logic [REQ_W-1:0]      q_data [NUM_CHAN];
  logic                  b_ack;
  logic                  b_valid_status;
  logic [AXI_ID_W-1:0]   b_id;
  logic [AXI_RESP_W-1:0] b_resp;

  host_regs i_host_regs (
    .clk            (clk),
    .rstn           (rstn),
    .host_addr      (host_addr),
    .host_din       (host_din),
    .host_en        (host_en),
    .host_we        (host_we),
    .host_dout      (host_dout),
    .push           (push),
    .push_data      (push_data),
    .credit_return  (credit_return),
    .b_valid_status (b_valid_status),
    .b_id           (b_id),
    .b_resp         (b_resp),
    .b_ack          (b_ack),
    .ocu_rstn       (ocu_rstn)
  );

  // one queue per address channel, indexed by chan_e
  for (genvar c = 0; c < NUM_CHAN; c++) begin : g_queue
    cmd_queue #(
      .DEPTH (QUEUE_DEPTH)
    ) i_cmd_queue (
      .clk           (clk),
      .rstn          (rstn),
      .push          (push[c]),
      .push_data     (push_data),
      .q_pop         (q_pop[c]),
      .q_valid       (q_valid[c]),
      .q_data        (q_data[c]),
      .credit_return (credit_return[c])
    );
  end

  axi_req_issue i_axi_req_issue (
    .clk            (clk),
    .rstn           (rstn),
    .q_valid        (q_valid),
    .q_data_aw      (q_data[CH_WRITE]),
    .q_data_ar      (q_data[CH_READ]),
    .q_pop          (q_pop),
    .awaddr         (awaddr),
    .awsize         (awsize),
    .awvalid        (awvalid),
    .awready        (awready),
    .araddr         (araddr),
    .arsize         (arsize),
    .arvalid        (arvalid),
    .arready        (arready),
    .bid            (bid),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .b_ack          (b_ack),
    .b_valid_status (b_valid_status),
    .b_id           (b_id),
    .b_resp         (b_resp)
  );

endmodule

//--- include/tb_host_tasks.svh
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// host port accesses start and end on a falling edge
task automatic host_write(input host_reg_e addr, input logic [HOST_DATA_W-1:0] data);
  host_addr = addr;
  host_din  = data;
  host_we   = 4'hf;
  host_en   = 1'b1;
  @(negedge clk);
  host_en = 1'b0;
  host_we = 4'h0;
endtask

task automatic host_read(input host_reg_e addr, output logic [HOST_DATA_W-1:0] data);
  host_addr = addr;
  host_we   = 4'h0;
  host_en   = 1'b1;
  @(negedge clk);
  host_en = 1'b0;
  data    = host_dout; // registered on the edge in between
endtask

task automatic wait_valid(input chan_e ch);
  int n;
  n = 0;
  while (!((ch == CH_WRITE) ? awvalid : arvalid) && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  if (!((ch == CH_WRITE) ? awvalid : arvalid)) begin
    timeouts++;
    $display("TIMEOUT %0t: %s never went high after a push", $time,
             (ch == CH_WRITE) ? "awvalid" : "arvalid");
  end
endtask

task automatic wait_seen(input chan_e ch, input int count);
  int n;
  n = 0;
  while (seen_count(ch) < count && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  if (seen_count(ch) < count) begin
    timeouts++;
    $display("TIMEOUT %0t: only %0d of %0d handshakes seen on channel %0d", $time,
             seen_count(ch), count, ch);
  end
endtask

task automatic wait_ocu_rstn(input logic level);
  int n;
  n = 0;
  while (ocu_rstn !== level && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  if (ocu_rstn !== level) begin
    timeouts++;
    $display("TIMEOUT %0t: ocu_rstn never reached %b", $time, level);
  end
endtask

task automatic wait_b_taken();
  int n;
  n = 0;
  while (!bready && n < TIMEOUT) begin
    @(negedge clk);
    n++;
  end
  if (!bready) begin
    timeouts++;
    $display("TIMEOUT %0t: bready stayed low, response not taken", $time);
  end
  @(negedge clk); // handshake on the edge in between
endtask

// poll until both counts match, then check them
task automatic wait_credits(input int aw_exp, input int ar_exp);
  logic [HOST_DATA_W-1:0] word;
  int n;
  n = 0;
  host_read(REG_CREDITS, word);
  while ((word[3:0] != aw_exp || word[11:8] != ar_exp) && n < TIMEOUT) begin
    host_read(REG_CREDITS, word);
    n++;
  end
  check_eq("credits aw", REQ_W'(word[3:0]), REQ_W'(aw_exp));
  check_eq("credits ar", REQ_W'(word[11:8]), REQ_W'(ar_exp));
endtask

`endif

//--- sim/tb_kernel_bridge.sv
`timescale 1ns/1ps

module tb_kernel_bridge;

  import xfer_pkg::*;

  localparam int SEED    = 13185;
  localparam int TIMEOUT = 200; // cycles per wait

  logic                   clk;
  logic                   rstn;
  logic [HOST_ADDR_W-1:0] host_addr;
  logic [HOST_DATA_W-1:0] host_din;
  logic [HOST_DATA_W-1:0] host_dout;
  logic                   host_en;
  logic [3:0]             host_we;
  logic                   ocu_rstn;
  logic [AXI_ADDR_W-1:0]  awaddr;
  logic [AXI_SIZE_W-1:0]  awsize;
  logic                   awvalid;
  logic                   awready;
  logic [AXI_ADDR_W-1:0]  araddr;
  logic [AXI_SIZE_W-1:0]  arsize;
  logic                   arvalid;
  logic                   arready;
  logic [AXI_ID_W-1:0]    bid;
  logic [AXI_RESP_W-1:0]  bresp;
  logic                   bvalid;
  logic                   bready;

  int               errors;
  int               timeouts;
  logic             aw_hold;
  logic             aw_stall;
  logic [REQ_W-1:0] aw_stall_data;
  logic [REQ_W-1:0] aw_seen [$];
  logic [REQ_W-1:0] ar_seen [$];

  kernel_bridge i_dut (
    .clk       (clk),
    .rstn      (rstn),
    .host_addr (host_addr),
    .host_din  (host_din),
    .host_dout (host_dout),
    .host_en   (host_en),
    .host_we   (host_we),
    .ocu_rstn  (ocu_rstn),
    .awaddr    (awaddr),
    .awsize    (awsize),
    .awvalid   (awvalid),
    .awready   (awready),
    .araddr    (araddr),
    .arsize    (arsize),
    .arvalid   (arvalid),
    .arready   (arready),
    .bid       (bid),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  always #50 clk = ~clk;

  task automatic check_eq(input string name, input logic [REQ_W-1:0] got,
                          input logic [REQ_W-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAILED %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  function automatic int seen_count(input chan_e ch);
    return (ch == CH_WRITE) ? aw_seen.size() : ar_seen.size();
  endfunction

  `include "tb_host_tasks.svh"

  task automatic stage_request(output logic [REQ_W-1:0] req);
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_SIZE_W-1:0] size;
    addr = {$urandom, $urandom};
    size = AXI_SIZE_W'($urandom);
    host_write(REG_STAGE0, addr[31:0]);
    host_write(REG_STAGE1, addr[63:32]);
    host_write(REG_STAGE2, HOST_DATA_W'(size));
    req = {size, addr};
  endtask

  // one request end to end on either channel
  task automatic issue_one(input chan_e ch);
    logic [REQ_W-1:0] req;
    stage_request(req);
    host_write((ch == CH_WRITE) ? REG_PUSH_AW : REG_PUSH_AR, 32'h1);
    wait_valid(ch);
    if (ch == CH_WRITE) begin
      check_eq("awaddr", REQ_W'(awaddr), REQ_W'(req[AXI_ADDR_W-1:0]));
      check_eq("awsize", REQ_W'(awsize), REQ_W'(req[REQ_W-1:AXI_ADDR_W]));
    end else begin
      check_eq("araddr", REQ_W'(araddr), REQ_W'(req[AXI_ADDR_W-1:0]));
      check_eq("arsize", REQ_W'(arsize), REQ_W'(req[REQ_W-1:AXI_ADDR_W]));
    end
    wait_seen(ch, 1);
    if (ch == CH_WRITE && aw_seen.size() > 0) begin
      check_eq("aw handshake", aw_seen.pop_front(), req);
    end else if (ch == CH_READ && ar_seen.size() > 0) begin
      check_eq("ar handshake", ar_seen.pop_front(), req);
    end
  endtask

  // AXI slave side with random ready gaps
  always @(negedge clk) begin
    awready = !aw_hold && ($urandom % 4 != 0);
    arready = ($urandom % 4 != 0);
  end

  always @(posedge clk) begin
    if (rstn && aw_stall) begin
      assert ({awvalid, awsize, awaddr} === {1'b1, aw_stall_data}) else begin
        errors++;
        $display("FAILED %0t: {awsize,awaddr} expected %h got %h", $time,
                 aw_stall_data, {awsize, awaddr});
      end
    end
    aw_stall      = rstn && awvalid && !awready;
    aw_stall_data = {awsize, awaddr};
    if (rstn && awvalid && awready) aw_seen.push_back({awsize, awaddr});
    if (rstn && arvalid && arready) ar_seen.push_back({arsize, araddr});
  end

  assert property (@(posedge clk) !rstn |-> (!ocu_rstn && !awvalid && !arvalid))
    else begin
      errors++;
      $display("FAILED %0t: ocu_rstn/awvalid/arvalid in reset expected 000 got %b%b%b",
               $time, ocu_rstn, awvalid, arvalid);
    end

  assert property (@(posedge clk) disable iff (!rstn) (awvalid && !awready) |=> awvalid)
    else begin
      errors++;
      $display("FAILED %0t: awvalid expected 1 got 0", $time);
    end

  assert property (@(posedge clk) disable iff (!rstn) (arvalid && !arready) |=> arvalid)
    else begin
      errors++;
      $display("FAILED %0t: arvalid expected 1 got 0", $time);
    end

  initial begin
    logic [HOST_DATA_W-1:0] word;
    logic [REQ_W-1:0]       req;
    logic [REQ_W-1:0]       exp_q [$];
    logic [AXI_ID_W-1:0]    b1_id;
    logic [AXI_ID_W-1:0]    b2_id;
    logic [AXI_RESP_W-1:0]  b1_resp;
    logic [AXI_RESP_W-1:0]  b2_resp;
    void'($urandom(SEED));
    errors    = 0;
    timeouts  = 0;
    clk       = 1'b0;
    rstn      = 1'b0;
    host_addr = '0;
    host_din  = '0;
    host_en   = 1'b0;
    host_we   = 4'h0;
    awready   = 1'b0;
    arready   = 1'b0;
    bid       = '0;
    bresp     = '0;
    bvalid    = 1'b0;
    aw_hold   = 1'b0;
    aw_stall  = 1'b0;

    repeat (3) begin
      @(negedge clk);
      check_eq("ocu_rstn", REQ_W'(ocu_rstn), '0);
      check_eq("awvalid", REQ_W'(awvalid), '0);
      check_eq("arvalid", REQ_W'(arvalid), '0);
    end
    rstn = 1'b1;
    host_read(REG_CREDITS, word);
    check_eq("credits", REQ_W'(word), REQ_W'({20'h0, 4'(QUEUE_DEPTH), 4'h0, 4'(QUEUE_DEPTH)}));
    host_read(REG_DROPS, word);
    check_eq("drops", REQ_W'(word), '0);
    check_eq("ocu_rstn", REQ_W'(ocu_rstn), 1);

    issue_one(CH_WRITE);
    issue_one(CH_READ);
    wait_credits(QUEUE_DEPTH, QUEUE_DEPTH);

    // one request parks in the output register, the rest fill the queue
    aw_hold = 1'b1;
    for (int k = 0; k <= QUEUE_DEPTH; k++) begin
      stage_request(req);
      exp_q.push_back(req);
      wait_credits((k < 2) ? QUEUE_DEPTH : QUEUE_DEPTH - k + 1, QUEUE_DEPTH);
      host_write(REG_PUSH_AW, 32'h1);
    end
    wait_credits(0, QUEUE_DEPTH);
    host_read(REG_DROPS, word);
    check_eq("drops", REQ_W'(word), '0);
    for (int k = 1; k <= 3; k++) begin
      host_write(REG_PUSH_AW, 32'h1);
      host_read(REG_DROPS, word);
      check_eq("drops", REQ_W'(word), REQ_W'(k));
    end
    check_eq("awvalid", REQ_W'(awvalid), 1);
    aw_hold = 1'b0;
    wait_seen(CH_WRITE, QUEUE_DEPTH + 1);
    while (exp_q.size() > 0 && aw_seen.size() > 0) begin
      check_eq("aw handshake", aw_seen.pop_front(), exp_q.pop_front());
    end
    check_eq("aw handshakes missing", REQ_W'(exp_q.size()), '0);
    wait_credits(QUEUE_DEPTH, QUEUE_DEPTH);

    b1_id   = AXI_ID_W'($urandom);
    b1_resp = AXI_RESP_W'($urandom);
    b2_id   = b1_id ^ AXI_ID_W'(1 + $urandom % 15);
    b2_resp = AXI_RESP_W'($urandom);
    bid     = b1_id;
    bresp   = b1_resp;
    bvalid  = 1'b1;
    wait_b_taken();
    bid   = b2_id; // second response waits on the full slot
    bresp = b2_resp;
    repeat (3) begin
      @(negedge clk);
      check_eq("bready", REQ_W'(bready), '0);
    end
    host_read(REG_BRESP, word);
    check_eq("bresp slot", REQ_W'(word), REQ_W'({1'b1, 23'h0, b1_id, 2'b00, b1_resp}));
    wait_b_taken();
    bvalid = 1'b0;
    host_read(REG_BRESP, word);
    check_eq("bresp slot", REQ_W'(word), REQ_W'({1'b1, 23'h0, b2_id, 2'b00, b2_resp}));
    host_read(REG_BRESP, word);
    check_eq("bresp valid", REQ_W'(word[31]), '0);

    host_write(REG_LINK_RST_SET, 32'h1);
    wait_ocu_rstn(1'b0);
    issue_one(CH_WRITE);
    issue_one(CH_READ);
    check_eq("ocu_rstn", REQ_W'(ocu_rstn), '0);
    host_write(REG_LINK_RST_CLR, 32'h1);
    wait_ocu_rstn(1'b1);
    wait_credits(QUEUE_DEPTH, QUEUE_DEPTH);

    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
verilog/xfer_pkg.sv
verilog/host_regs.sv
verilog/cmd_queue.sv
verilog/axi_req_issue.sv
verilog/kernel_bridge.sv
sim/tb_kernel_bridge.sv

//--- Makefile
# Verilator build and run of the kernel bridge testbench

SIM  := obj_dir/Vtb_kernel_bridge
SRCS := $(filter-out +%,$(shell cat build.f)) include/tb_host_tasks.svh

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_kernel_bridge -f build.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
